// ==== sens_pkg.sv ====
// --------------------------------------------------------------------------
// shared widths, register map, command data union, channel write/status types
// --------------------------------------------------------------------------
`default_nettype none

package sens_pkg;

    localparam int frame_cnt_w = 16;            // frame counter width
    localparam int line_cnt_w  = 16;            // late-sof line counter width
    localparam int late_dflt   = 15;            // late sof line count out of reset

    // register numbers inside one channel address block
    localparam int reg_mode    = 0;             // mode word, chn_en in bit 0
    localparam int reg_mult    = 1;             // decimation, frames to combine minus 1
    localparam int reg_late    = 2;             // lines from sof to late sof
    localparam int reg_status  = 3;             // any write requests a status packet

    // mode register layout
    typedef struct packed {
        logic [30:0] rsvd;                      // not used yet
        logic        chn_en;                    // channel enable
    } sens_mode_t;

    // command data word, seen as a mode word or a plain count
    typedef union packed {
        sens_mode_t  mode;                      // reg_mode writes
        logic [31:0] count;                     // reg_mult / reg_late writes
    } cmd_data_u;

    // decoded writes for one channel
    typedef struct packed {
        logic      we_mode;                     // single-cycle strobes
        logic      we_mult;
        logic      we_late;
        logic      we_status;
        cmd_data_u data;                        // valid with any strobe
    } chn_wr_t;

    // per-channel status, 3 bytes of the status packet
    typedef struct packed {
        logic [15:0] frame_cnt;                 // bytes 1, 2
        logic        chn_en;                    // byte 3 bit 0
        logic        late_wait;                 // byte 3 bit 1
        logic [5:0]  rsvd;
    } chn_status_t;

endpackage

`default_nettype wire

// ==== sens_cmd_decoder.sv ====
// --------------------------------------------------------------------------
// byte-serial command deserializer and per-channel register write decoder
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sens_cmd_decoder #(
    parameter int          num_chn      = 4,     // 1..4
    parameter int unsigned group_addr   = 'h400, // channel 0 block
    parameter int unsigned chn_addr_inc = 'h40   // block stride
) (
    input  logic              mclk,
    input  logic              rst,
    input  logic [7:0]        cmd_ad,            // AL, AH, D0..D3
    input  logic              cmd_stb,           // with AL
    output sens_pkg::chn_wr_t chn_wr [num_chn]
);
    import sens_pkg::*;

    logic [2:0]         byte_cnt;                // next byte number, 0 = idle
    logic [39:0]        sr;                      // AL, AH, D0..D2 once full
    logic               cmd_done;                // D3 on the bus now
    logic [15:0]        cmd_addr;
    cmd_data_u          cmd_data;
    logic [15:0]        blk_off [num_chn];       // address minus block base
    logic [num_chn-1:0] hit;
    logic [3:0]         we_r [num_chn];          // {status, late, mult, mode}
    logic [num_chn-1:0] wr_any;
    cmd_data_u          data_r;

    // byte counter, cmd_stb always restarts
    always_ff @(posedge mclk) begin
        if (rst) begin
            byte_cnt <= '0;
        end else if (cmd_stb) begin
            byte_cnt <= 3'd1;                    // AL taken now
        end else if (byte_cnt == 3'd5) begin
            byte_cnt <= '0;                      // D3 taken, done
        end else if (byte_cnt != '0) begin
            byte_cnt <= byte_cnt + 3'd1;
        end
    end

    // shift in at the top, AL ends up in the low byte
    always_ff @(posedge mclk) begin
        if (cmd_stb || byte_cnt != '0) begin
            sr <= {cmd_ad, sr[39:8]};
        end
    end

    assign cmd_done       = (byte_cnt == 3'd5) && !cmd_stb;
    assign cmd_addr       = sr[15:0];            // {AH, AL}
    assign cmd_data.count = {cmd_ad, sr[39:16]}; // D3 straight from the bus

    always_comb begin
        for (int c = 0; c < num_chn; c++) begin
            blk_off[c] = cmd_addr - 16'(group_addr + c * chn_addr_inc);
            hit[c]     = (blk_off[c] < 16'd4);   // 4 registers per block
        end
    end

    // strobes one cycle after D3
    always_ff @(posedge mclk) begin
        if (rst) begin
            for (int c = 0; c < num_chn; c++) begin
                we_r[c] <= '0;
            end
        end else begin
            for (int c = 0; c < num_chn; c++) begin
                we_r[c] <= '0;
                if (cmd_done && hit[c]) begin
                    we_r[c][blk_off[c][1:0]] <= 1'b1; // one-hot by register number
                end
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_done) begin
            data_r <= cmd_data;                  // shared by all channels
        end
    end

    always_comb begin
        for (int c = 0; c < num_chn; c++) begin
            chn_wr[c].we_mode   = we_r[c][reg_mode];
            chn_wr[c].we_mult   = we_r[c][reg_mult];
            chn_wr[c].we_late   = we_r[c][reg_late];
            chn_wr[c].we_status = we_r[c][reg_status];
            chn_wr[c].data      = data_r;
            wr_any[c]           = |we_r[c];
        end
    end

    // channel blocks must not overlap
    a_one_chn: assert property (@(posedge mclk) disable iff (rst) $onehot0(wr_any))
        else $error("write strobes to more than one channel");

endmodule

`default_nettype wire

// ==== frame_sync.sv ====
// --------------------------------------------------------------------------
// per-channel frame sync with decimation, late sof, frame count, status flag
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module frame_sync (
    input  logic                  mclk,
    input  logic                  rst,
    input  sens_pkg::chn_wr_t     chn_wr,        // decoded register writes
    input  logic                  sof_in,        // sensor events, already on mclk
    input  logic                  line_in,
    input  logic                  eof_in,
    input  logic                  status_grant,  // packet taken by the router
    output logic                  sof_out,
    output logic                  sof_late,
    output sens_pkg::chn_status_t status,
    output logic                  status_rq
);
    import sens_pkg::*;

    logic                   chn_en;
    logic [frame_cnt_w-1:0] mult_r;              // frames to combine minus 1
    logic [frame_cnt_w-1:0] dec_cnt;
    logic [frame_cnt_w-1:0] frame_cnt;
    logic [line_cnt_w-1:0]  late_r;
    logic [line_cnt_w-1:0]  line_cnt;
    logic [line_cnt_w-1:0]  line_nxt;
    logic                   late_wait;           // between sof and late sof
    logic                   accept;
    logic                   out_seen;            // sof_out not yet followed by sof_late

    // control registers
    always_ff @(posedge mclk) begin
        if (rst) begin
            chn_en    <= 1'b0;
            mult_r    <= '0;
            late_r    <= line_cnt_w'(late_dflt);
            status_rq <= 1'b0;
        end else begin
            if (chn_wr.we_mode) chn_en <= chn_wr.data.mode.chn_en;
            if (chn_wr.we_mult) mult_r <= chn_wr.data.count[frame_cnt_w-1:0];
            if (chn_wr.we_late) late_r <= chn_wr.data.count[line_cnt_w-1:0];
            if (chn_wr.we_status) begin
                status_rq <= 1'b1;               // new request beats the grant
            end else if (status_grant) begin
                status_rq <= 1'b0;
            end
        end
    end

    // decimation, counts all sof_in while enabled
    always_ff @(posedge mclk) begin
        if (rst || !chn_en) begin
            dec_cnt <= '0;
        end else if (sof_in) begin
            dec_cnt <= (dec_cnt >= mult_r) ? '0 : dec_cnt + 1'b1; // >= covers a smaller new mult
        end
    end

    assign accept   = chn_en && sof_in && (dec_cnt == '0);
    assign line_nxt = line_cnt + 1'b1;

    // sof outputs, frame counter, late line wait
    always_ff @(posedge mclk) begin
        if (rst) begin
            sof_out   <= 1'b0;
            sof_late  <= 1'b0;
            late_wait <= 1'b0;
            line_cnt  <= '0;
            frame_cnt <= '0;
        end else begin
            sof_out  <= accept;
            sof_late <= 1'b0;
            if (accept) begin
                frame_cnt <= frame_cnt + 1'b1;
                line_cnt  <= '0;
                if (late_r == '0) begin
                    sof_late  <= 1'b1;           // same cycle as sof_out
                    late_wait <= 1'b0;
                end else begin
                    late_wait <= 1'b1;
                end
            end else if (late_wait) begin
                if (eof_in || (line_in && line_nxt == late_r)) begin
                    sof_late  <= 1'b1;           // eof cuts the wait short
                    late_wait <= 1'b0;
                end else if (line_in) begin
                    line_cnt <= line_nxt;
                end
            end
        end
    end

    assign status = '{frame_cnt: frame_cnt, chn_en: chn_en, late_wait: late_wait, rsvd: '0};

    always_ff @(posedge mclk) begin
        if (rst) begin
            out_seen <= 1'b0;
        end else begin
            out_seen <= (sof_out || out_seen) && !sof_late;
        end
    end

    // every late sof belongs to an earlier or simultaneous sof_out
    a_late_after_sof: assert property (@(posedge mclk) disable iff (rst)
        sof_late |-> (sof_out || out_seen))
        else $error("sof_late without a preceding sof_out");

endmodule

`default_nettype wire

// ==== status_router.sv ====
// --------------------------------------------------------------------------
// round-robin status arbiter, 4-byte packet serializer
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module status_router #(
    parameter int          num_chn          = 4,
    parameter int unsigned status_addr_base = 'h20  // channel c at base + 2c
) (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic [num_chn-1:0]    chn_rq,           // per-channel request levels
    input  sens_pkg::chn_status_t chn_status [num_chn],
    input  logic                  status_start,     // host takes the address byte
    output logic [num_chn-1:0]    status_grant,     // one-hot pulse
    output logic [7:0]            status_ad,
    output logic                  status_rq
);
    import sens_pkg::*;

    localparam int idx_w = (num_chn > 1) ? $clog2(num_chn) : 1;

    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_offer = 3'd1;         // address byte out, rq high
    localparam logic [2:0] st_b1    = 3'd2;         // frame_cnt low out
    localparam logic [2:0] st_b2    = 3'd3;         // frame_cnt high out
    localparam logic [2:0] st_b3    = 3'd4;         // flags out

    logic [2:0]       state;
    logic [idx_w-1:0] last_r;                       // channel served last
    logic [idx_w-1:0] sel_r;                        // channel offered now
    logic [idx_w-1:0] nxt;
    chn_status_t      word_r;                       // snapshot at status_start

    // first requester after last_r with wrap-around
    always_comb begin
        nxt = last_r;
        for (int k = num_chn; k >= 1; k--) begin
            if (chn_rq[(int'(last_r) + k) % num_chn]) begin
                nxt = idx_w'((int'(last_r) + k) % num_chn);
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (rst) begin
            state        <= st_idle;
            last_r       <= idx_w'(num_chn - 1);    // channel 0 wins first
            sel_r        <= '0;
            status_rq    <= 1'b0;
            status_grant <= '0;
            status_ad    <= '0;
        end else begin
            status_grant <= '0;
            case (state)
                st_idle, st_b3: begin               // next offer right after byte 3
                    if (|chn_rq) begin
                        state     <= st_offer;
                        sel_r     <= nxt;
                        status_rq <= 1'b1;
                        status_ad <= 8'(status_addr_base + 2 * int'(nxt));
                    end else begin
                        state     <= st_idle;
                        status_ad <= '0;
                    end
                end
                st_offer: begin
                    if (status_start) begin
                        state               <= st_b1;
                        status_rq           <= 1'b0;
                        status_grant[sel_r] <= 1'b1;
                        last_r              <= sel_r;
                        status_ad           <= chn_status[sel_r].frame_cnt[7:0];
                    end
                end
                st_b1: begin
                    state     <= st_b2;
                    status_ad <= word_r.frame_cnt[15:8];
                end
                st_b2: begin
                    state     <= st_b3;
                    status_ad <= {6'b0, word_r.late_wait, word_r.chn_en};
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (state == st_offer && status_start) begin
            word_r <= chn_status[sel_r];
        end
    end

    // host may only acknowledge a pending offer
    a_start_rq: assert property (@(posedge mclk) disable iff (rst)
        status_start |-> status_rq)
        else $error("status_start without status_rq");

    // grant goes to one channel only and that channel is still requesting
    a_grant_1hot: assert property (@(posedge mclk) disable iff (rst)
        $onehot0(status_grant) && ((status_grant & ~chn_rq) == '0))
        else $error("status_grant not one-hot or given to an idle channel");

endmodule

`default_nettype wire

// ==== sensors_top.sv ====
// --------------------------------------------------------------------------
// sensor frame-sync subsystem top, command decoder, channels, status router
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sensors_top #(
    parameter int          num_chn          = 4,
    parameter int unsigned group_addr       = 'h400,
    parameter int unsigned chn_addr_inc     = 'h40,
    parameter int unsigned status_addr_base = 'h20
) (
    input  logic               mclk,
    input  logic               rst,
    input  logic [7:0]         cmd_ad,           // byte-serial command port
    input  logic               cmd_stb,
    input  logic [num_chn-1:0] sof_in,           // sensor events
    input  logic [num_chn-1:0] line_in,
    input  logic [num_chn-1:0] eof_in,
    output logic [num_chn-1:0] sof_out,
    output logic [num_chn-1:0] sof_late,
    output logic [7:0]         status_ad,        // status port
    output logic               status_rq,
    input  logic               status_start
);
    import sens_pkg::*;

    chn_wr_t            chn_wr     [num_chn];
    chn_status_t        chn_status [num_chn];
    logic [num_chn-1:0] chn_rq;
    logic [num_chn-1:0] chn_grant;

    sens_cmd_decoder #(
        .num_chn      (num_chn),
        .group_addr   (group_addr),
        .chn_addr_inc (chn_addr_inc)
    ) u_cmd_dec (
        .mclk    (mclk),
        .rst     (rst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .chn_wr  (chn_wr)
    );

    for (genvar i = 0; i < num_chn; i++) begin : g_chn
        frame_sync u_fsync (
            .mclk         (mclk),
            .rst          (rst),
            .chn_wr       (chn_wr[i]),
            .sof_in       (sof_in[i]),
            .line_in      (line_in[i]),
            .eof_in       (eof_in[i]),
            .status_grant (chn_grant[i]),
            .sof_out      (sof_out[i]),
            .sof_late     (sof_late[i]),
            .status       (chn_status[i]),
            .status_rq    (chn_rq[i])
        );
    end

    status_router #(
        .num_chn          (num_chn),
        .status_addr_base (status_addr_base)
    ) u_router (
        .mclk         (mclk),
        .rst          (rst),
        .chn_rq       (chn_rq),
        .chn_status   (chn_status),
        .status_start (status_start),
        .status_grant (chn_grant),
        .status_ad    (status_ad),
        .status_rq    (status_rq)
    );

endmodule

`default_nettype wire

// ==== tb_sensors.sv ====
// --------------------------------------------------------------------------
// sensors_top testbench with reference model, monitor, compare task and tests
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_sensors;

    localparam int num_chn          = 4;
    localparam int group_addr       = 'h400;
    localparam int chn_addr_inc     = 'h40;
    localparam int status_addr_base = 'h20;

    logic               mclk;
    logic               rst;
    logic [7:0]         cmd_ad;
    logic               cmd_stb;
    logic [num_chn-1:0] sof_in;
    logic [num_chn-1:0] line_in;
    logic [num_chn-1:0] eof_in;
    logic [num_chn-1:0] sof_out;
    logic [num_chn-1:0] sof_late;
    logic [7:0]         status_ad;
    logic               status_rq;
    logic               status_start;

    int         cyc = 0;                         // rising edges since start
    int         sof_cnt [num_chn];               // monitor counts
    int         late_cnt [num_chn];
    int         rq_cnt = 0;                      // cycles with status_rq high
    int         out_q[$];                        // sof_out cycles of channel 0
    int         late_q[$];
    int         line_q[$];                       // line_in drive cycles of the late test
    logic [7:0] byte_q[$];                       // status bytes with the address first
    int         pkt_left = 0;
    int         last_drv;                        // cycle of the last driven strobe
    int         n_checks = 0;
    int         n_errors = 0;

    logic        m_en [num_chn];                 // reference model state
    logic [15:0] m_mult [num_chn];
    logic [15:0] m_late [num_chn];
    logic [15:0] m_fcnt [num_chn];
    logic        m_lw [num_chn];                 // waiting for late sof
    int          m_dec [num_chn];
    int          m_line [num_chn];

    sensors_top #(
        .num_chn          (num_chn),
        .group_addr       (group_addr),
        .chn_addr_inc     (chn_addr_inc),
        .status_addr_base (status_addr_base)
    ) u_dut (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .sof_in       (sof_in),
        .line_in      (line_in),
        .eof_in       (eof_in),
        .sof_out      (sof_out),
        .sof_late     (sof_late),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;                 // 100 MHz
    end

    always @(posedge mclk) cyc <= cyc + 1;

    // monitor samples on the falling edge where outputs have settled
    always @(negedge mclk) begin
        if (!rst) begin
            for (int c = 0; c < num_chn; c++) begin
                if (sof_out[c]) sof_cnt[c]++;
                if (sof_late[c]) late_cnt[c]++;
            end
            if (sof_out[0]) out_q.push_back(cyc);
            if (sof_late[0]) late_q.push_back(cyc);
            if (status_rq) rq_cnt++;
            if (status_start) begin
                byte_q.push_back(status_ad);     // address byte of the offer
                pkt_left = 3;
            end else if (pkt_left > 0) begin
                byte_q.push_back(status_ad);
                pkt_left--;
            end
        end
    end

    // decimation keeps sof number idx when it lands on a multiple of mult+1
    function automatic bit sof_passes(input int idx, input int mult);
        return (idx % (mult + 1)) == 0;
    endfunction

    // late sof cycle from the sof, line and eof drive cycles
    function automatic int exp_late_cyc(input int sof_cyc, input int late, input int eof_cyc);
        if (late == 0) return sof_cyc + 1;
        for (int i = 0; i < line_q.size(); i++) begin
            if (eof_cyc < line_q[i]) return eof_cyc + 1;    // eof came first
            if (i + 1 == late) return line_q[i] + 1;
        end
        return eof_cyc + 1;
    endfunction

    // packet as {flags, frame_cnt hi, frame_cnt lo, address}
    function automatic logic [31:0] exp_packet(input int c);
        return {6'b0, m_lw[c], m_en[c], m_fcnt[c], 8'(status_addr_base + 2 * c)};
    endfunction

    function automatic int seen_count(input int kind, input int c);
        if (kind == 0) return sof_cnt[c];
        if (kind == 1) return late_cnt[c];
        return byte_q.size();
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic test_done(input string name, input int err0);
        $display("%s: %s", name, (n_errors == err0) ? "ok" : "mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAIL");
        $finish;
    endtask

    // move to 1 ns past the next edge and clear all strobes
    task automatic step();
        @(posedge mclk);
        #1;
        cmd_stb      = 1'b0;
        sof_in       = '0;
        line_in      = '0;
        eof_in       = '0;
        status_start = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic wait_count(input int kind, input int c, input int n, input string what);
        int t;
        t = 0;
        while (seen_count(kind, c) < n && t < 200) begin
            t++;
            step();
        end
        if (seen_count(kind, c) < n) begin
            abort_run(what);
        end
    endtask

    // send AL, AH, D0..D3 and update the model by the address map
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] frame;
        int          base;
        frame = {data, addr};
        for (int i = 0; i < 6; i++) begin
            step();
            cmd_stb = (i == 0);
            cmd_ad  = frame[i*8 +: 8];
        end
        step();
        cmd_ad = '0;
        idle(2);                                 // strobe lands one cycle after D3
        for (int c = 0; c < num_chn; c++) begin
            base = group_addr + c * chn_addr_inc;
            if (int'(addr) == base) begin
                m_en[c] = data[0];
                if (!data[0]) m_dec[c] = 0;
            end
            if (int'(addr) == base + 1) m_mult[c] = data[15:0];
            if (int'(addr) == base + 2) m_late[c] = data[15:0];
        end
    endtask

    task automatic send_sof(input logic [num_chn-1:0] mask);
        step();
        sof_in   = mask;
        last_drv = cyc;
        for (int c = 0; c < num_chn; c++) begin
            if (mask[c] && m_en[c]) begin
                if (m_dec[c] == 0) begin
                    m_fcnt[c] = m_fcnt[c] + 16'd1;
                    m_lw[c]   = (m_late[c] != 0);
                    m_line[c] = 0;
                end
                m_dec[c] = (m_dec[c] + 1) % (int'(m_mult[c]) + 1);
            end
        end
    endtask

    task automatic send_line(input int c);
        step();
        line_in[c] = 1'b1;
        last_drv   = cyc;
        if (m_lw[c] && m_line[c] + 1 == int'(m_late[c])) m_lw[c] = 1'b0;
        else if (m_lw[c]) m_line[c]++;
    endtask

    task automatic send_eof(input int c);
        step();
        eof_in[c] = 1'b1;
        last_drv  = cyc;
        m_lw[c]   = 1'b0;
    endtask

    // ack the pending offer
    task automatic take_packet();
        int t;
        t = 0;
        step();
        while (status_rq !== 1'b1 && t < 200) begin
            t++;
            step();
        end
        if (status_rq !== 1'b1) begin
            abort_run("a status offer");
        end
        status_start = 1'b1;
    endtask

    initial begin
        int          e0;
        int          late;
        int          sof_cyc;
        int          base;
        int          sof0_base;
        int          sof2_base;
        int          fcnt0_base;
        int          exp_q[$];
        logic [31:0] pkt1;
        logic [31:0] pkt3;
        void'($urandom(10));
        {cmd_ad, cmd_stb, sof_in, line_in, eof_in, status_start} = '0;
        for (int c = 0; c < num_chn; c++) begin
            {m_en[c], m_mult[c], m_fcnt[c], m_lw[c], m_dec[c], m_line[c]} = '0;
            {sof_cnt[c], late_cnt[c]} = '0;
            m_late[c] = 16'(sens_pkg::late_dflt);
        end
        rst = 1'b1;
        repeat (16) @(posedge mclk);
        #1 rst = 1'b0;

        e0 = n_errors;                           // nothing enabled yet
        for (int i = 0; i < 3; i++) send_sof('1);
        send_line(0);
        send_eof(0);
        idle(4);
        for (int c = 0; c < num_chn; c++) begin
            check("reset_idle sof", 0, sof_cnt[c] + late_cnt[c]);
        end
        check("reset_idle status_rq", 0, rq_cnt);
        test_done("reset_idle", e0);

        e0 = n_errors;
        write_reg(16'(group_addr + 1), 32'd2);
        write_reg(16'(group_addr), 32'd1);
        for (int i = 0; i < 9; i++) begin
            send_sof(4'b0001);
            if (sof_passes(i, 2)) exp_q.push_back(last_drv + 1);
            idle($urandom_range(3, 1));
        end
        wait_count(0, 0, exp_q.size(), "decimated sof_out");
        idle(4);
        check("decimation count", exp_q.size(), out_q.size());
        for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
            check("decimation cycle", exp_q[i], out_q[i]);
        end
        test_done("decimation", e0);

        e0 = n_errors;
        late = $urandom_range(6, 1);
        write_reg(16'(group_addr + 1), 32'd0);
        write_reg(16'(group_addr + 2), 32'(late));
        for (int pass = 0; pass < 2; pass++) begin   // pass 1 cuts the wait short by eof
            base = late_cnt[0];
            late_q.delete();
            line_q.delete();
            send_sof(4'b0001);
            sof_cyc = last_drv;
            for (int i = 0; i < ((pass == 0) ? late + 2 : late - 1); i++) begin
                idle($urandom_range(2, 0));
                send_line(0);
                line_q.push_back(last_drv);
            end
            send_eof(0);
            wait_count(1, 0, base + 1, "sof_late");
            idle(4);
            check("late_sof count", base + 1, late_cnt[0]);
            check("late_sof cycle", exp_late_cyc(sof_cyc, late, last_drv), late_q[0]);
        end
        test_done("late_sof", e0);

        e0 = n_errors;
        write_reg(16'(group_addr + chn_addr_inc), 32'd1);
        for (int i = 0; i < 3; i++) send_sof(4'b0010);
        write_reg(16'(group_addr + 3 * chn_addr_inc + 2), 32'd0);  // late sof with sof_out
        write_reg(16'(group_addr + 3 * chn_addr_inc), 32'd1);
        for (int i = 0; i < 2; i++) send_sof(4'b1000);
        wait_count(1, 3, 2, "late sof on channel 3");
        pkt1 = exp_packet(1);
        pkt3 = exp_packet(3);
        byte_q.delete();
        write_reg(16'(group_addr + chn_addr_inc + 3), 32'd0);      // both pending before any ack
        write_reg(16'(group_addr + 3 * chn_addr_inc + 3), 32'd0);
        take_packet();
        wait_count(2, 0, 4, "first status packet");
        take_packet();
        wait_count(2, 0, 8, "second status packet");
        idle(3);
        check("status packet 1", pkt1, {byte_q[3], byte_q[2], byte_q[1], byte_q[0]});
        check("status packet 2", pkt3, {byte_q[7], byte_q[6], byte_q[5], byte_q[4]});
        check("status rq after", 0, status_rq);
        test_done("status", e0);

        e0 = n_errors;
        base       = rq_cnt;
        sof0_base  = sof_cnt[0];
        sof2_base  = sof_cnt[2];
        fcnt0_base = int'(m_fcnt[0]);
        write_reg(16'(group_addr - 1), 32'd0);                     // just below channel 0
        write_reg(16'(group_addr + 2 * chn_addr_inc + 4), 32'd1);  // just past channel 2
        write_reg(16'(group_addr + 4 * chn_addr_inc), 32'd0);      // past the last block
        for (int i = 0; i < 4; i++) begin
            send_sof(4'b0101);
            idle($urandom_range(3, 1));
        end
        wait_count(0, 0, sof0_base + int'(m_fcnt[0]) - fcnt0_base, "channel 0 sof_out");
        idle(4);
        check("isolation ch0 sof_out", sof0_base + int'(m_fcnt[0]) - fcnt0_base, sof_cnt[0]);
        check("isolation ch2 sof_out", sof2_base, sof_cnt[2]);
        check("isolation status_rq", base, rq_cnt);
        test_done("isolation", e0);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
sens_pkg.sv
sens_cmd_decoder.sv
frame_sync.sv
status_router.sv
sensors_top.sv
tb_sensors.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sensors testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_sensors -f tb.f -o Vtb_sensors
./obj_dir/Vtb_sensors | tee sim.log
if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
